/* spi_frame_pkg.sv */
// ======================================================================
// SPI frame layout shared by the receiver, capture and decoder blocks
// ======================================================================
// A frame is 16 bytes sent MSB first in SPI Mode 0
// Byte 0 is the header, bytes 1 to 6 carry roll, pitch and yaw
// Bytes 7 to 12 carry the gyro rates, byte 13 holds the flags
// Bytes 14 and 15 are reserved and ignored by the decoder
// Every 16-bit field is sent MSB byte first, then LSB byte

package spi_frame_pkg;

    // Number of bytes in one complete frame
    localparam int frame_bytes = 16;

    // Value the master puts in byte 0 of every good frame
    localparam logic [7:0] header_byte = 8'hAA;

    // Byte positions of the fields within the frame
    localparam int header_pos = 0;
    // First byte of the roll/pitch/yaw block
    localparam int euler_pos = 1;
    // First byte of the gyro x/y/z block
    localparam int gyro_pos = 7;
    // Single byte holding the valid flags
    localparam int flags_pos = 13;

    // Write pointer into the frame buffer
    // Four bits cover 16 bytes, so a long transaction wraps back to byte 0
    typedef logic [3:0] byte_index_t;

    // Frame buffer, one byte per position
    // Element 0 holds the header byte
    typedef logic [frame_bytes-1:0][7:0] frame_buf_t;

endpackage

/* sensor_pkg.sv */
// ======================================================================
// Decoded sensor data types
// ======================================================================
// Angles are signed 16-bit values scaled by 100 (0.01 degree per LSB)
// Gyro rates are signed 16-bit values scaled by 2000
// Both groups share the same three-axis struct

package sensor_pkg;

    // One signed value per axis
    // For the Euler group x is roll, y is pitch and z is yaw
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } axis_triple_t;

    // Bit positions in the flags byte
    // Bit 0 marks the Euler angles as valid
    localparam int flag_euler_bit = 0;
    // Bit 1 marks the gyro rates as valid
    localparam int flag_gyro_bit = 1;

    // Everything the decoder presents for one good frame
    typedef struct packed {
        axis_triple_t euler;
        axis_triple_t gyro;
        logic         euler_valid;
        logic         gyro_valid;
    } sensor_sample_t;

    // clk cycles the synchronized select must stay high before capture
    // This gives any late sck edge time to settle in the frame buffer
    localparam int stable_cycles = 3;

    // Counter width that can hold the value stable_cycles
    localparam int stable_cnt_w = $clog2(stable_cycles + 1);

endpackage

/* spi_frame_rx.sv */
`timescale 1ns/1ps

// SPI Mode 0 receiver running entirely on the master's sck
// Data is sampled on the rising edge of sck, MSB first
module spi_frame_rx import spi_frame_pkg::*; (
    input  logic       sck,
    input  logic       spi_sel_n,
    input  logic       sdi,
    input  logic       cs_n,
    output frame_buf_t frame_buf
);

    // ==================================================================
    // Bit and byte tracking
    // ==================================================================

    // Number of bits already shifted into the current byte
    logic [2:0]  bit_cnt;
    // The first seven bits of the byte in flight
    logic [6:0]  rx_shift;
    // Position the next completed byte is written to
    byte_index_t byte_idx;

    // Byte completed on this edge, the eighth bit goes in as the LSB
    logic [7:0]  rx_byte;
    // High on the sck edge that carries the last bit of a byte
    logic        byte_done;

    assign rx_byte   = {rx_shift, sdi};
    assign byte_done = (bit_cnt == 3'd7);

    // Counters clear asynchronously whenever the master deselects us
    // In Mode 0 sck idles low, so no edge arrives while the select is high
    // A new transaction therefore always starts at byte 0, bit 0
    always_ff @(posedge sck or posedge cs_n or posedge spi_sel_n) begin
        if (cs_n || spi_sel_n) begin
            bit_cnt  <= '0;
            rx_shift <= '0;
            byte_idx <= '0;
        end else if (byte_done) begin
            bit_cnt  <= '0;
            rx_shift <= '0;
            // The 4-bit pointer wraps from byte 15 back to the header position
            byte_idx <= byte_idx + 1'b1;
        end else begin
            // Earlier bits move up one place as each new bit arrives
            rx_shift <= {rx_shift[5:0], sdi};
            bit_cnt  <= bit_cnt + 1'b1;
        end
    end

    // ==================================================================
    // Frame buffer
    // ==================================================================

    // Only the addressed byte is written, the rest keep their old value
    // A short frame thus leaves the tail of the previous frame in place
    // The buffer survives deselect so the clk side can copy it afterwards
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            frame_buf <= '0;
        end else if (!spi_sel_n && byte_done) begin
            frame_buf[byte_idx] <= rx_byte;
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // A byte completes on the eighth bit of its group and never later
    // The written byte then holds the last eight sdi bits, oldest as the MSB
    a_byte_msb_first: assert property (
        @(posedge sck) disable iff (cs_n || spi_sel_n)
        byte_done |-> rx_byte == {$past(sdi, 7), $past(sdi, 6), $past(sdi, 5),
                                  $past(sdi, 4), $past(sdi, 3), $past(sdi, 2),
                                  $past(sdi, 1), sdi}
    ) else $error("spi_frame_rx: byte not completed on the eighth bit MSB first");

endmodule

/* frame_capture.sv */
`timescale 1ns/1ps

// Moves the sck-domain frame buffer into the clk domain
// The copy is taken only once the select has been high and stable,
// which means sck is idle and the buffer no longer changes
module frame_capture import spi_frame_pkg::*; import sensor_pkg::*; (
    input  logic       clk,
    input  logic       cs_n,
    input  logic       spi_sel_n,
    input  frame_buf_t frame_buf,
    output frame_buf_t snapshot,
    output logic       snapshot_valid,
    output logic       select_active
);

    // ==================================================================
    // Select synchronizer and edge detect
    // ==================================================================

    logic sel_meta;
    logic sel_sync;
    // Previous synchronized select, for the falling edge detect
    logic sel_prev;
    logic sel_fall;

    // Cycles the synchronized select has been high, saturating
    logic [stable_cnt_w-1:0] stable_cnt;
    // One capture allowed until the next select fall
    logic armed;
    // Copy the buffer on this cycle
    logic capture;

    assign sel_fall = sel_prev && !sel_sync;

    // Capture on the cycle the counter reaches stable_cycles
    // The counter resets saturated, so a select held high through reset
    // never counts up to the threshold and no empty frame is taken
    assign capture = sel_sync && armed &&
                     (stable_cnt == stable_cnt_w'(stable_cycles - 1));

    // Diagnostic level, high while the master is talking to us
    assign select_active = !sel_sync;

    // ==================================================================
    // Control state
    // ==================================================================

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            // The synchronizer starts in the idle (deselected) state
            sel_meta       <= 1'b1;
            sel_sync       <= 1'b1;
            sel_prev       <= 1'b1;
            stable_cnt     <= stable_cnt_w'(stable_cycles);
            armed          <= 1'b1;
            snapshot_valid <= 1'b0;
        end else begin
            sel_meta       <= spi_sel_n;
            sel_sync       <= sel_meta;
            sel_prev       <= sel_sync;
            snapshot_valid <= capture;

            // Any low sample restarts the stable window
            if (!sel_sync) begin
                stable_cnt <= '0;
            end else if (stable_cnt != stable_cnt_w'(stable_cycles)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end

            // Armed from reset so the very first transaction is taken
            if (capture) begin
                armed <= 1'b0;
            end else if (sel_fall) begin
                armed <= 1'b1;
            end
        end
    end

    // All 16 bytes are copied in the same cycle, never byte by byte
    always_ff @(posedge clk) begin
        if (capture) begin
            snapshot <= frame_buf;
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // A snapshot is only announced after the select sat high for the
    // whole stable window
    a_capture_sel_high: assert property (
        @(posedge clk) disable iff (cs_n)
        snapshot_valid |-> $past(sel_sync, 1) && $past(sel_sync, stable_cycles)
    ) else $error("frame_capture: snapshot taken without a stable select");

endmodule

/* frame_decoder.sv */
`timescale 1ns/1ps

// Splits a captured frame into its fields and checks the header
// Two register stages, so frame_strobe follows snapshot_valid by 2 cycles
module frame_decoder import spi_frame_pkg::*; import sensor_pkg::*; (
    input  logic           clk,
    input  logic           cs_n,
    input  frame_buf_t     snapshot,
    input  logic           snapshot_valid,
    output sensor_sample_t sample,
    output logic           initialized,
    output logic           error,
    output logic           frame_strobe
);

    // ==================================================================
    // Field extraction helpers
    // ==================================================================

    // Builds a signed value from an MSB byte and the LSB byte after it
    function automatic logic signed [15:0] field16(
        input frame_buf_t  frame,
        input int unsigned msb_pos
    );
        return {frame[msb_pos], frame[msb_pos + 1]};
    endfunction

    // Three consecutive 16-bit fields, in x, y, z order
    function automatic axis_triple_t triple_at(
        input frame_buf_t  frame,
        input int unsigned first_pos
    );
        axis_triple_t t;
        t.x = field16(frame, first_pos);
        t.y = field16(frame, first_pos + 2);
        t.z = field16(frame, first_pos + 4);
        return t;
    endfunction

    // ==================================================================
    // Stage 1 field registers
    // ==================================================================

    logic [7:0]   header_q;
    axis_triple_t euler_q;
    axis_triple_t gyro_q;
    logic [7:0]   flags_q;
    // Field registers hold a new frame this cycle
    logic         fields_valid;
    logic         header_ok;

    // Fields only load with a new snapshot and hold otherwise
    always_ff @(posedge clk) begin
        if (snapshot_valid) begin
            header_q <= snapshot[header_pos];
            euler_q  <= triple_at(snapshot, euler_pos);
            gyro_q   <= triple_at(snapshot, gyro_pos);
            flags_q  <= snapshot[flags_pos];
        end
    end

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            fields_valid <= 1'b0;
        end else begin
            fields_valid <= snapshot_valid;
        end
    end

    assign header_ok = (header_q == header_byte);

    // ==================================================================
    // Stage 2 status and output registers
    // ==================================================================

    // Status and sample change together with the strobe
    // A bad header flags an error but keeps the last good sample on the outputs
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            sample       <= '0;
            initialized  <= 1'b0;
            error        <= 1'b0;
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= fields_valid;
            if (fields_valid) begin
                initialized <= header_ok;
                error       <= !header_ok;
                if (header_ok) begin
                    sample.euler       <= euler_q;
                    sample.gyro        <= gyro_q;
                    sample.euler_valid <= flags_q[flag_euler_bit];
                    sample.gyro_valid  <= flags_q[flag_gyro_bit];
                end
            end
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // Status is either good or bad, never both
    a_status_exclusive: assert property (
        @(posedge clk) disable iff (cs_n)
        !(initialized && error)
    ) else $error("frame_decoder: initialized and error both high");

    // The sample only moves together with the strobe of a good frame
    a_sample_on_good_strobe: assert property (
        @(posedge clk) disable iff (cs_n)
        $changed(sample) |-> frame_strobe && initialized
    ) else $error("frame_decoder: sample changed outside a good frame");

endmodule

/* imu_link_top.sv */
`timescale 1ns/1ps

// ======================================================================
// SPI sensor link, read-only Mode 0 slave
// ======================================================================
// Data path from the master to the outputs
//   spi_frame_rx   assembles bytes on sck into the frame buffer
//   frame_capture  copies the buffer into the clk domain after deselect
//   frame_decoder  checks the header and registers the sample
// The frame buffer is the only signal that crosses from sck to clk
// It is read only while the select is high and sck is idle
module imu_link_top import spi_frame_pkg::*; import sensor_pkg::*; (
    input  logic           clk,
    input  logic           cs_n,
    input  logic           sck,
    input  logic           spi_sel_n,
    input  logic           sdi,
    output sensor_sample_t sample,
    output logic           initialized,
    output logic           error,
    output logic           frame_strobe,
    output logic           select_active
);

    // Frame buffer in the sck domain
    frame_buf_t frame_buf;
    // Frame copy in the clk domain
    frame_buf_t snapshot;
    logic       snapshot_valid;

    // Receiver on the master's clock
    spi_frame_rx u_spi_frame_rx (
        .sck       (sck),
        .spi_sel_n (spi_sel_n),
        .sdi       (sdi),
        .cs_n      (cs_n),
        .frame_buf (frame_buf)
    );

    // Clock domain crossing of the whole frame
    frame_capture u_frame_capture (
        .clk            (clk),
        .cs_n           (cs_n),
        .spi_sel_n      (spi_sel_n),
        .frame_buf      (frame_buf),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid),
        .select_active  (select_active)
    );

    // Field decode and status
    frame_decoder u_frame_decoder (
        .clk            (clk),
        .cs_n           (cs_n),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid),
        .sample         (sample),
        .initialized    (initialized),
        .error          (error),
        .frame_strobe   (frame_strobe)
    );

endmodule

/* imu_link_tb_tasks.svh */
// ======================================================================
// Bookkeeping
// ======================================================================

task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    test_errors++;
endtask

task automatic end_test(input string name);
    if (test_errors == 0) begin
        tests_passed++;
        $display("test %s: passed", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
endtask

// ======================================================================
// SPI master and reference model
// ======================================================================

// Full frame: header, 12 random field bytes, flags, 2 random reserved bytes
task automatic load_full_frame(input logic [7:0] header, input logic [7:0] flags);
    logic [31:0] r;
    int          b;
    tx_bytes.delete();
    tx_bytes.push_back(header);
    for (b = 1; b < 16; b++) begin
        r = $random(seed);
        tx_bytes.push_back((b == 13) ? flags : r[7:0]);
    end
endtask

// Mode 0, MSB first; sdi changes while sck is low, 100 ns per sck phase
// Bytes past 15 land at the start of the buffer again
task automatic spi_transfer();
    int b;
    int k;
    sel_active_seen = 1'b0;
    spi_sel_n = 1'b0;
    repeat (5) @(negedge clk);
    for (b = 0; b < tx_bytes.size(); b++) begin
        for (k = 7; k >= 0; k--) begin
            sdi = tx_bytes[b][k];
            repeat (5) @(negedge clk);
            sck = 1'b1;
            if (select_active) begin
                sel_active_seen = 1'b1;
            end
            repeat (5) @(negedge clk);
            sck = 1'b0;
        end
        ref_buf[b % 16] = tx_bytes[b];
    end
    repeat (5) @(negedge clk);
    spi_sel_n = 1'b1;
endtask

// A good header loads the sample, a bad one only flips the status
task automatic update_expected();
    if (ref_buf[0] == 8'hAA) begin
        exp_sample.euler.x     = {ref_buf[1], ref_buf[2]};
        exp_sample.euler.y     = {ref_buf[3], ref_buf[4]};
        exp_sample.euler.z     = {ref_buf[5], ref_buf[6]};
        exp_sample.gyro.x      = {ref_buf[7], ref_buf[8]};
        exp_sample.gyro.y      = {ref_buf[9], ref_buf[10]};
        exp_sample.gyro.z      = {ref_buf[11], ref_buf[12]};
        exp_sample.euler_valid = ref_buf[13][0];
        exp_sample.gyro_valid  = ref_buf[13][1];
        exp_init = 1'b1;
        exp_err  = 1'b0;
    end else begin
        exp_init = 1'b0;
        exp_err  = 1'b1;
    end
endtask

// Waits for the strobe of the last transaction and checks the outputs there
task automatic check_frame(input string what);
    logic seen;
    int   n;
    seen = 1'b0;
    for (n = 0; n < 200 && !seen; n++) begin
        @(negedge clk);
        seen = frame_strobe;
    end
    if (!seen) begin
        $display("ERROR at %0t ns: no frame_strobe within 200 cycles after %s", $time, what);
        test_errors++;
    end else begin
        if (sample !== exp_sample) begin
            report_mismatch($sformatf("%s: sample %h, expected %h", what, sample, exp_sample));
        end
        if (initialized !== exp_init || error !== exp_err) begin
            report_mismatch($sformatf("%s: initialized/error %b%b, expected %b%b",
                                      what, initialized, error, exp_init, exp_err));
        end
        @(negedge clk);
        if (frame_strobe !== 1'b0) begin
            report_mismatch($sformatf("%s: frame_strobe high for more than one cycle", what));
        end
    end
    // Idle gap before the next transaction
    repeat (20) @(negedge clk);
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic test_reset_state();
    if (initialized !== 1'b0 || error !== 1'b0 || frame_strobe !== 1'b0) begin
        report_mismatch("status outputs not low after reset");
    end
    if (select_active !== 1'b0 || sample !== '0) begin
        report_mismatch($sformatf("select_active %b sample %h after reset", select_active, sample));
    end
    end_test("reset_state");
endtask

task automatic test_full_frame();
    load_full_frame(8'hAA, 8'h03);
    spi_transfer();
    update_expected();
    if (!sel_active_seen) begin
        report_mismatch("select_active stayed low during the transaction");
    end
    check_frame("full frame");
    if (sample.euler_valid !== 1'b1 || sample.gyro_valid !== 1'b1) begin
        report_mismatch("valid bits not both set for flags 3");
    end
    end_test("full_frame");
endtask

task automatic test_flag_mapping();
    load_full_frame(8'hAA, 8'h01);
    spi_transfer();
    update_expected();
    check_frame("flags 1");
    if (sample.euler_valid !== 1'b1 || sample.gyro_valid !== 1'b0) begin
        report_mismatch("flags 1 should give euler_valid only");
    end
    load_full_frame(8'hAA, 8'h02);
    spi_transfer();
    update_expected();
    check_frame("flags 2");
    if (sample.euler_valid !== 1'b0 || sample.gyro_valid !== 1'b1) begin
        report_mismatch("flags 2 should give gyro_valid only");
    end
    end_test("flag_mapping");
endtask

// The sample must keep the last good frame through a bad header
task automatic test_bad_header();
    load_full_frame(8'h3C, 8'h03);
    spi_transfer();
    update_expected();
    check_frame("bad header");
    load_full_frame(8'hAA, 8'h03);
    spi_transfer();
    update_expected();
    check_frame("good frame after bad header");
    end_test("bad_header");
endtask

// Header plus a new roll value, the rest comes from the older frame
task automatic test_short_frame();
    logic [31:0] r;
    r = $random(seed);
    tx_bytes.delete();
    tx_bytes.push_back(8'hAA);
    tx_bytes.push_back(r[15:8]);
    tx_bytes.push_back(r[7:0]);
    spi_transfer();
    update_expected();
    check_frame("3-byte frame");
    if (sample.euler.x !== r[15:0]) begin
        report_mismatch($sformatf("roll %h, expected %h", sample.euler.x, r[15:0]));
    end
    end_test("short_frame");
endtask

// Bad header in byte 0 is overwritten by a good one in byte 16
task automatic test_wrap_frame();
    logic [31:0] r;
    r = $random(seed);
    load_full_frame(8'h55, 8'h03);
    tx_bytes.push_back(8'hAA);
    tx_bytes.push_back(r[7:0]);
    spi_transfer();
    update_expected();
    check_frame("18-byte frame");
    if (sample.euler.x[15:8] !== r[7:0]) begin
        report_mismatch($sformatf("roll MSB %h, expected %h", sample.euler.x[15:8], r[7:0]));
    end
    end_test("wrap_frame");
endtask

/* imu_link_tb.sv */
`timescale 1ns/1ps

// Testbench for the SPI sensor link
// The master side is modelled by tasks, and a byte-level model of the
// frame buffer gives the sample that the DUT should present at each strobe
module imu_link_tb import sensor_pkg::*; ();

    // ==================================================================
    // Clock, reset and DUT
    // ==================================================================

    logic clk;
    logic cs_n;
    logic sck;
    logic spi_sel_n;
    logic sdi;

    sensor_sample_t sample;
    logic           initialized;
    logic           error;
    logic           frame_strobe;
    logic           select_active;

    imu_link_top dut0 (
        .clk           (clk),
        .cs_n          (cs_n),
        .sck           (sck),
        .spi_sel_n     (spi_sel_n),
        .sdi           (sdi),
        .sample        (sample),
        .initialized   (initialized),
        .error         (error),
        .frame_strobe  (frame_strobe),
        .select_active (select_active)
    );

    // 20 ns clock period
    always #10 clk = ~clk;

    // ==================================================================
    // Reference model and counters
    // ==================================================================

    // What the slave's frame buffer should hold after each transaction
    logic [7:0]     ref_buf [16];
    // Bytes of the next transaction, in the order they go on the wire
    logic [7:0]     tx_bytes [$];
    sensor_sample_t exp_sample;
    logic           exp_init;
    logic           exp_err;
    // Set when select_active was seen high during the last transaction
    logic           sel_active_seen;
    integer         seed;
    int             test_errors;
    int             tests_passed;
    int             tests_failed;

    `include "imu_link_tb_tasks.svh"

    initial begin
        int i;
        clk       = 1'b0;
        cs_n      = 1'b1;
        sck       = 1'b0;
        spi_sel_n = 1'b1;
        sdi       = 1'b0;
        seed      = 32'h9d8d_0604;
        tests_passed = 0;
        tests_failed = 0;
        test_errors  = 0;
        sel_active_seen = 1'b0;
        // After reset the buffer and the outputs are all zero
        for (i = 0; i < 16; i++) begin
            ref_buf[i] = 8'h00;
        end
        exp_sample = '0;
        exp_init   = 1'b0;
        exp_err    = 1'b0;

        // Reset held for 4 full cycles, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        cs_n = 1'b0;
        @(negedge clk);

        test_reset_state();
        test_full_frame();
        test_flag_mapping();
        test_bad_header();
        test_short_frame();
        test_wrap_frame();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
spi_frame_pkg.sv
sensor_pkg.sv
spi_frame_rx.sv
frame_capture.sv
frame_decoder.sv
imu_link_top.sv
imu_link_tb.sv
